// File: include/led_panel_params.svh
`ifndef LED_PANEL_PARAMS_SVH
`define LED_PANEL_PARAMS_SVH

////////////////////////////////////////////////////////////
// Panel geometry
////////////////////////////////////////////////////////////

// Driver chains, one sin line each
`define LED_NUM_CHAINS 4
// Bits per chain word, power of two
`define LED_CHAIN_BITS 16
`define LED_FRAME_BITS (`LED_NUM_CHAINS * `LED_CHAIN_BITS)

// Cycles with gclk held low after the latch
`define LED_BLANKING_CYCLES 16

////////////////////////////////////////////////////////////
// Host status port
////////////////////////////////////////////////////////////

`define LED_WB_DATA_BITS     16
`define LED_WB_ADDR_BITS     2
`define LED_FRAME_COUNT_BITS 16

// Word addresses
`define LED_REG_SELECT   2'd0
`define LED_REG_READBACK 2'd1
`define LED_REG_FRAMES   2'd2

`endif

// File: verilog/led_panel_pkg.sv
`default_nettype none

`include "led_panel_params.svh"

package led_panel_pkg;

  // One chain's worth of panel data
  typedef logic [`LED_CHAIN_BITS-1:0] chain_word_t;

  // Chain index, also the sout_mux value
  typedef logic [$clog2(`LED_NUM_CHAINS)-1:0] chain_sel_t;

  typedef logic [`LED_WB_DATA_BITS-1:0] wb_data_t;
  typedef logic [`LED_WB_ADDR_BITS-1:0] wb_addr_t;

  // Completed frames, wraps
  typedef logic [`LED_FRAME_COUNT_BITS-1:0] frame_count_t;

  typedef enum logic [1:0] {idle, shifting, latching, blanking} loader_state_t;

endpackage

`default_nettype wire

// File: verilog/frame_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "led_panel_params.svh"

module frame_loader (
  input  wire  clock_33,
  input  wire  nrst,
  input  wire  fb_data,
  input  wire  fb_sync,
  output led_panel_pkg::chain_word_t [`LED_NUM_CHAINS-1:0] chain_words,
  output logic load,
  output logic shift_step,
  output logic frame_done,
  output logic sclk,
  output logic lat,
  output logic gclk
);

  ////////////////////////////////////////////////////////////
  // Frame intake
  ////////////////////////////////////////////////////////////

  logic [$clog2(`LED_FRAME_BITS)-1:0] bit_pos;
  logic [$clog2(`LED_FRAME_BITS)-1:0] cur_pos;
  logic                               collecting;
  logic                               in_frame;
  logic                               last_bit;
  led_panel_pkg::chain_sel_t          chain_idx;
  logic [$clog2(`LED_CHAIN_BITS)-1:0] word_idx;

  led_panel_pkg::chain_word_t [`LED_NUM_CHAINS-1:0] collect;
  led_panel_pkg::chain_word_t [`LED_NUM_CHAINS-1:0] collect_next;

  // A sync always restarts at bit 0
  assign cur_pos  = fb_sync ? '0 : bit_pos;
  assign in_frame = fb_sync | collecting;
  assign last_bit = in_frame && (cur_pos == `LED_FRAME_BITS - 1);

  // Upper bits pick the chain, lower bits count down from the MSB
  assign chain_idx = cur_pos[$clog2(`LED_FRAME_BITS)-1:$clog2(`LED_CHAIN_BITS)];
  assign word_idx  = ~cur_pos[$clog2(`LED_CHAIN_BITS)-1:0];

  always_comb begin
    collect_next = collect;
    collect_next[chain_idx][word_idx] = fb_data;
  end

  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      bit_pos    <= '0;
      collecting <= 1'b0;
      load       <= 1'b0;
    end else begin
      load <= last_bit;
      if (in_frame) begin
        bit_pos    <= cur_pos + 1'b1;
        collecting <= !last_bit;
      end
    end
  end

  // Words leave for the shifters on the last bit, next frame fills behind
  always_ff @(posedge clock_33) begin
    if (in_frame)
      collect <= collect_next;
    if (last_bit)
      chain_words <= collect_next;
  end

  ////////////////////////////////////////////////////////////
  // Shift, latch and blanking sequencer
  ////////////////////////////////////////////////////////////

  led_panel_pkg::loader_state_t state;
  led_panel_pkg::loader_state_t state_next;
  logic phase;
  logic [$clog2(`LED_CHAIN_BITS + `LED_BLANKING_CYCLES)-1:0] seq_cnt;

  always_comb begin
    state_next = state;
    case (state)
      led_panel_pkg::idle: begin
        if (load)
          state_next = led_panel_pkg::shifting;
      end
      led_panel_pkg::shifting: begin
        if (phase && seq_cnt == `LED_CHAIN_BITS - 1)
          state_next = led_panel_pkg::latching;
      end
      led_panel_pkg::latching: begin
        state_next = led_panel_pkg::blanking;
      end
      led_panel_pkg::blanking: begin
        if (seq_cnt == `LED_BLANKING_CYCLES - 1)
          state_next = led_panel_pkg::idle;
      end
      default: state_next = led_panel_pkg::idle;
    endcase
  end

  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      state   <= led_panel_pkg::idle;
      phase   <= 1'b0;
      seq_cnt <= '0;
      gclk    <= 1'b0;
    end else begin
      state <= state_next;
      // gclk runs except through latch and blanking
      if (state_next == led_panel_pkg::latching || state_next == led_panel_pkg::blanking)
        gclk <= 1'b0;
      else
        gclk <= ~gclk;
      if (state_next != state) begin
        phase   <= 1'b0;
        seq_cnt <= '0;
      end else if (state == led_panel_pkg::shifting) begin
        phase <= ~phase;
        if (phase)
          seq_cnt <= seq_cnt + 1'b1;
      end else if (state == led_panel_pkg::blanking) begin
        seq_cnt <= seq_cnt + 1'b1;
      end
    end
  end

  // Low phase sets up sin, high phase is the sclk pulse
  assign shift_step = (state == led_panel_pkg::shifting) && phase;
  assign sclk       = shift_step;
  assign lat        = (state == led_panel_pkg::latching);
  assign frame_done = lat;

endmodule

`default_nettype wire

// File: verilog/chain_shifter.sv
`timescale 1ns/10ps
`default_nettype none

`include "led_panel_params.svh"

module chain_shifter (
  input  wire                              clock_33,
  input  wire                              nrst,
  input  wire led_panel_pkg::chain_word_t  word,
  input  wire                              load,
  input  wire                              shift_step,
  output logic                             sin
);

  ////////////////////////////////////////////////////////////
  // Output shift register, MSB first
  ////////////////////////////////////////////////////////////

  led_panel_pkg::chain_word_t shift_reg;

  // Advances after the sclk high cycle, so the next bit
  // is set up during the following low phase
  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      shift_reg <= '0;
    end else if (load) begin
      shift_reg <= word;
    end else if (shift_step) begin
      shift_reg <= {shift_reg[`LED_CHAIN_BITS-2:0], 1'b0};
    end
  end

  // Current bit on the chain input
  assign sin = shift_reg[`LED_CHAIN_BITS-1];

endmodule

`default_nettype wire

// File: verilog/status_collector.sv
`timescale 1ns/10ps
`default_nettype none

`include "led_panel_params.svh"

module status_collector (
  input  wire                            clock_33,
  input  wire                            nrst,
  input  wire                            sout,
  input  wire                            shift_step,
  input  wire                            frame_done,
  input  wire                            wb_cyc,
  input  wire                            wb_stb,
  input  wire                            wb_we,
  input  wire led_panel_pkg::wb_addr_t   wb_adr,
  input  wire led_panel_pkg::wb_data_t   wb_dat_w,
  output led_panel_pkg::wb_data_t        wb_dat_r,
  output logic                           wb_ack,
  output led_panel_pkg::chain_sel_t      sout_mux
);

  ////////////////////////////////////////////////////////////
  // Readback of the selected chain
  ////////////////////////////////////////////////////////////

  logic                         sout_q;
  led_panel_pkg::chain_word_t   capture;
  led_panel_pkg::chain_word_t   readback;
  led_panel_pkg::frame_count_t  frame_count;

  // Input flop on the returned line, holds the bit seen
  // during the sclk low phase before the chain shifts
  always_ff @(posedge clock_33) begin
    sout_q <= sout;
    if (shift_step)
      capture <= {capture[`LED_CHAIN_BITS-2:0], sout_q};
  end

  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      readback    <= '0;
      frame_count <= '0;
    end else if (frame_done) begin
      readback    <= capture;
      frame_count <= frame_count + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Wishbone classic slave
  ////////////////////////////////////////////////////////////

  logic wb_access;

  // Single-cycle ack; the ~wb_ack term keeps a held strobe from
  // being acknowledged twice
  assign wb_access = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      wb_ack   <= 1'b0;
      sout_mux <= '0;
    end else begin
      wb_ack <= wb_access;
      // Only the select register is writable
      if (wb_access && wb_we && wb_adr == `LED_REG_SELECT)
        sout_mux <= led_panel_pkg::chain_sel_t'(wb_dat_w);
    end
  end

  // Read data lines up with the ack
  always_ff @(posedge clock_33) begin
    if (wb_access) begin
      case (wb_adr)
        `LED_REG_SELECT:   wb_dat_r <= led_panel_pkg::wb_data_t'(sout_mux);
        `LED_REG_READBACK: wb_dat_r <= led_panel_pkg::wb_data_t'(readback);
        `LED_REG_FRAMES:   wb_dat_r <= led_panel_pkg::wb_data_t'(frame_count);
        default:           wb_dat_r <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/led_driver_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "led_panel_params.svh"

module led_driver_top (
  input  wire                            clock_33,
  input  wire                            nrst,
  input  wire                            fb_data,
  input  wire                            fb_sync,
  input  wire                            sout,
  input  wire                            wb_cyc,
  input  wire                            wb_stb,
  input  wire                            wb_we,
  input  wire led_panel_pkg::wb_addr_t   wb_adr,
  input  wire led_panel_pkg::wb_data_t   wb_dat_w,
  output wire [`LED_NUM_CHAINS-1:0]      sin,
  output wire                            sclk,
  output wire                            lat,
  output wire                            gclk,
  output wire led_panel_pkg::chain_sel_t sout_mux,
  output wire led_panel_pkg::wb_data_t   wb_dat_r,
  output wire                            wb_ack
);

  wire led_panel_pkg::chain_word_t [`LED_NUM_CHAINS-1:0] chain_words;
  wire load;
  wire shift_step;
  wire frame_done;

  ////////////////////////////////////////////////////////////
  // Framebuffer intake and sequencing
  ////////////////////////////////////////////////////////////

  frame_loader frame_loader_inst (
    .clock_33    (clock_33),
    .nrst        (nrst),
    .fb_data     (fb_data),
    .fb_sync     (fb_sync),
    .chain_words (chain_words),
    .load        (load),
    .shift_step  (shift_step),
    .frame_done  (frame_done),
    .sclk        (sclk),
    .lat         (lat),
    .gclk        (gclk)
  );

  // One shifter per driver chain, all on the shared sclk
  for (genvar i = 0; i < `LED_NUM_CHAINS; i++) begin : g_chain
    chain_shifter chain_shifter_inst (
      .clock_33   (clock_33),
      .nrst       (nrst),
      .word       (chain_words[i]),
      .load       (load),
      .shift_step (shift_step),
      .sin        (sin[i])
    );
  end

  ////////////////////////////////////////////////////////////
  // Host status port
  ////////////////////////////////////////////////////////////

  status_collector status_collector_inst (
    .clock_33   (clock_33),
    .nrst       (nrst),
    .sout       (sout),
    .shift_step (shift_step),
    .frame_done (frame_done),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .sout_mux   (sout_mux)
  );

endmodule

`default_nettype wire

// File: test/led_driver_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "led_panel_params.svh"

module led_driver_properties (
  input wire clock_33,
  input wire nrst,
  input wire sclk,
  input wire lat,
  input wire gclk,
  input wire wb_cyc,
  input wire wb_stb,
  input wire wb_ack
);

  // Cycles left in the blanking interval after lat
  int blank_left;

  always_ff @(posedge clock_33) begin
    if (!nrst)
      blank_left <= 0;
    else if (lat)
      blank_left <= `LED_BLANKING_CYCLES;
    else if (blank_left != 0)
      blank_left <= blank_left - 1;
  end

  ////////////////////////////////////////////////////////////
  // Panel timing
  ////////////////////////////////////////////////////////////

  lat_one_cycle: assert property (@(posedge clock_33) disable iff (!nrst)
    lat |=> !lat)
    else $error("lat high for more than one cycle");

  blank_clocks_low: assert property (@(posedge clock_33) disable iff (!nrst)
    (lat || blank_left != 0) |-> (!sclk && !gclk))
    else $error("sclk or gclk high during blanking");

  no_sclk_after_lat: assert property (@(posedge clock_33) disable iff (!nrst)
    $rose(sclk) |-> (blank_left == 0))
    else $error("sclk rose within the blanking interval");

  // Host port
  ack_inside_strobe: assert property (@(posedge clock_33) disable iff (!nrst)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("wb_ack high without cyc and stb");

endmodule

bind led_driver_top led_driver_properties led_driver_properties_inst (
  .clock_33 (clock_33),
  .nrst     (nrst),
  .sclk     (sclk),
  .lat      (lat),
  .gclk     (gclk),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_ack   (wb_ack)
);

`default_nettype wire

// File: test/led_driver_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "led_panel_params.svh"

module led_driver_tb;

  // Frames sent over all tests, the partial one included
  localparam int TOTAL_FRAMES = 11;
  localparam int FRAME_CYCLES = 80;
  localparam int WATCHDOG_NS  = TOTAL_FRAMES * FRAME_CYCLES * 4 + 2000;

  logic                              clock_33;
  logic                              nrst;
  logic                              fb_data;
  logic                              fb_sync;
  wire                               sout;
  logic                              wb_cyc;
  logic                              wb_stb;
  logic                              wb_we;
  led_panel_pkg::wb_addr_t           wb_adr;
  led_panel_pkg::wb_data_t           wb_dat_w;
  wire [`LED_NUM_CHAINS-1:0]         sin;
  wire                               sclk;
  wire                               lat;
  wire                               gclk;
  wire led_panel_pkg::chain_sel_t    sout_mux;
  wire led_panel_pkg::wb_data_t      wb_dat_r;
  wire                               wb_ack;

  integer seed = 34347;
  int errors = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int frames_sent = 0;
  int lat_count = 0;
  int ack_count = 0;
  int host_accesses = 0;
  int rises;
  int blank_left;
  logic sclk_prev;
  logic gclk_prev;
  logic gclk_valid;
  logic [`LED_FRAME_BITS-1:0] expected_frames [$];
  logic [`LED_FRAME_BITS-1:0] shifted_frame;
  led_panel_pkg::chain_word_t chain_model [`LED_NUM_CHAINS];
  led_panel_pkg::chain_word_t seen_words [`LED_NUM_CHAINS];

  led_driver_top led_driver_top_inst (
    .clock_33 (clock_33),
    .nrst     (nrst),
    .fb_data  (fb_data),
    .fb_sync  (fb_sync),
    .sout     (sout),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .sin      (sin),
    .sclk     (sclk),
    .lat      (lat),
    .gclk     (gclk),
    .sout_mux (sout_mux),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    clock_33 = 1'b0;
    forever #2 clock_33 = ~clock_33;
  end

  ////////////////////////////////////////////////////////////
  // External chains in loopback
  ////////////////////////////////////////////////////////////

  // Each chain clocks in its sin bit during the sclk pulse
  always @(posedge clock_33) begin : chain_loopback
    for (int i = 0; i < `LED_NUM_CHAINS; i++) begin
      if (!nrst)
        chain_model[i] <= '0;
      else if (sclk)
        chain_model[i] <= {chain_model[i][`LED_CHAIN_BITS-2:0], sin[i]};
    end
  end

  assign sout = nrst ? chain_model[sout_mux][`LED_CHAIN_BITS-1] : 1'b0;

  // Frame bit k goes to chain k/16, MSB of the word first
  function automatic led_panel_pkg::chain_word_t chain_word_of(
    input logic [`LED_FRAME_BITS-1:0] frame,
    input int                         chain
  );
    led_panel_pkg::chain_word_t word;
    for (int b = 0; b < `LED_CHAIN_BITS; b++)
      word[`LED_CHAIN_BITS-1-b] = frame[chain * `LED_CHAIN_BITS + b];
    return word;
  endfunction

  function automatic logic [`LED_FRAME_BITS-1:0] random_frame();
    return {$random(seed), $random(seed)};
  endfunction

  ////////////////////////////////////////////////////////////
  // Output comparison
  ////////////////////////////////////////////////////////////

  always @(posedge clock_33) begin : compare_outputs
    led_panel_pkg::chain_word_t expected;
    logic [`LED_FRAME_BITS-1:0] frame;
    logic in_blank;
    if (!nrst) begin
      rises      = 0;
      blank_left = 0;
      sclk_prev  = 1'b0;
      gclk_valid = 1'b0;
    end else begin
      if (sclk && !sclk_prev) begin
        rises++;
        for (int i = 0; i < `LED_NUM_CHAINS; i++)
          seen_words[i] = {seen_words[i][`LED_CHAIN_BITS-2:0], sin[i]};
      end
      sclk_prev = sclk;
      if (wb_ack)
        ack_count++;
      // Latch cycle plus the blanking cycles after it
      in_blank = lat || (blank_left != 0);
      if (in_blank && gclk !== 1'b0) begin
        $display("MISMATCH at %0t: gclk high during latch or blanking", $time);
        errors++;
      end
      if (!in_blank && gclk_valid && gclk === gclk_prev) begin
        $display("MISMATCH at %0t: gclk did not toggle outside blanking", $time);
        errors++;
      end
      if (lat) begin
        lat_count++;
        if (rises != `LED_CHAIN_BITS) begin
          $display("MISMATCH at %0t: %0d sclk rises before latch, expected 16", $time, rises);
          errors++;
        end
        if (expected_frames.size() == 0) begin
          $display("ERROR at %0t: latch pulse with no frame sent", $time);
          errors++;
        end else begin
          frame = expected_frames.pop_front();
          for (int i = 0; i < `LED_NUM_CHAINS; i++) begin
            expected = chain_word_of(frame, i);
            if (seen_words[i] !== expected) begin
              $display("MISMATCH at %0t: chain %0d shifted %h, expected %h",
                       $time, i, seen_words[i], expected);
              errors++;
            end
          end
        end
        rises      = 0;
        blank_left = `LED_BLANKING_CYCLES;
      end else if (blank_left != 0) begin
        blank_left--;
      end
      gclk_prev  = gclk;
      gclk_valid = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic drive_bits(input logic [`LED_FRAME_BITS-1:0] frame, input int nbits);
    for (int k = 0; k < nbits; k++) begin
      @(posedge clock_33);
      #1;
      fb_sync = (k == 0);
      fb_data = frame[k];
    end
  endtask

  task automatic send_frame(input logic [`LED_FRAME_BITS-1:0] frame);
    expected_frames.push_back(frame);
    frames_sent++;
    drive_bits(frame, `LED_FRAME_BITS);
    repeat (FRAME_CYCLES - `LED_FRAME_BITS) begin
      @(posedge clock_33);
      #1;
      fb_sync = 1'b0;
      fb_data = 1'b0;
    end
  endtask

  task automatic wait_latch();
    int cycles;
    cycles = 0;
    while (lat_count < frames_sent && cycles < 200) begin
      @(posedge clock_33);
      #1;
      cycles++;
    end
    if (lat_count < frames_sent) begin
      $display("ERROR at %0t: no latch pulse for frame %0d", $time, frames_sent);
      errors++;
    end
  endtask

  // Classic single cycle, held until ack, released one cycle later
  task automatic host_access(
    input  logic                    we,
    input  led_panel_pkg::wb_addr_t adr,
    input  led_panel_pkg::wb_data_t wdata,
    output led_panel_pkg::wb_data_t rdata
  );
    int cycles;
    @(posedge clock_33);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    host_accesses++;
    cycles = 0;
    do begin
      @(posedge clock_33);
      #1;
      cycles++;
    end while (!wb_ack && cycles < 20);
    rdata = wb_dat_r;
    if (!wb_ack) begin
      $display("ERROR at %0t: no acknowledge for address %0d", $time, adr);
      errors++;
    end
    @(posedge clock_33);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (wb_ack) begin
      $display("ERROR at %0t: acknowledge lasted more than one cycle", $time);
      errors++;
    end
  endtask

  task automatic host_write(input led_panel_pkg::wb_addr_t adr, input int value);
    led_panel_pkg::wb_data_t unused;
    host_access(1'b1, adr, led_panel_pkg::wb_data_t'(value), unused);
  endtask

  task automatic host_read_check(
    input led_panel_pkg::wb_addr_t adr,
    input led_panel_pkg::wb_data_t expected,
    input string                   what
  );
    led_panel_pkg::wb_data_t rdata;
    host_access(1'b0, adr, '0, rdata);
    if (rdata !== expected) begin
      $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, rdata, expected);
      errors++;
    end
  endtask

  task automatic start_test();
    test_errors = errors;
    tests_run++;
  endtask

  task automatic finish_test(input string name);
    if (errors == test_errors) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s with %0d errors", name, errors - test_errors);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [`LED_FRAME_BITS-1:0] frame;
    nrst          = 1'b0;
    fb_data       = 1'b0;
    fb_sync       = 1'b0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    shifted_frame = '0;
    repeat (8) @(posedge clock_33);
    #1;

    start_test();
    if (sclk !== 1'b0 || lat !== 1'b0 || gclk !== 1'b0 || wb_ack !== 1'b0) begin
      $display("MISMATCH at %0t: sclk, lat, gclk or wb_ack not low in reset", $time);
      errors++;
    end
    if (sin !== '0 || sout_mux !== '0) begin
      $display("MISMATCH at %0t: sin or sout_mux not zero in reset", $time);
      errors++;
    end
    nrst = 1'b1;
    host_read_check(`LED_REG_READBACK, '0, "readback after reset");
    host_read_check(`LED_REG_FRAMES, '0, "frame count after reset");
    finish_test("reset_values");

    start_test();
    for (int n = 0; n < 4; n++) begin
      frame = random_frame();
      send_frame(frame);
      shifted_frame = frame;
    end
    wait_latch();
    finish_test("shift_and_gclk");

    // Readback returns what each chain held before the frame
    start_test();
    for (int s = 0; s < `LED_NUM_CHAINS; s++) begin
      host_write(`LED_REG_SELECT, s);
      if (sout_mux !== led_panel_pkg::chain_sel_t'(s)) begin
        $display("MISMATCH at %0t: sout_mux %0d, expected %0d", $time, sout_mux, s);
        errors++;
      end
      frame = random_frame();
      send_frame(frame);
      wait_latch();
      host_read_check(`LED_REG_READBACK, chain_word_of(shifted_frame, s), "readback");
      shifted_frame = frame;
    end
    finish_test("readback_select");

    start_test();
    host_write(`LED_REG_SELECT, 2);
    host_write(`LED_REG_READBACK, 16'hffff);
    host_write(`LED_REG_FRAMES, 16'h0001);
    host_write(2'd3, 16'h0003);
    if (sout_mux !== led_panel_pkg::chain_sel_t'(2)) begin
      $display("MISMATCH at %0t: sout_mux %0d after other writes, expected 2",
               $time, sout_mux);
      errors++;
    end
    host_read_check(`LED_REG_SELECT, 16'd2, "select register");
    frame = random_frame();
    send_frame(frame);
    wait_latch();
    if (lat_count != frames_sent) begin
      $display("ERROR at %0t: %0d latch pulses for %0d frames sent",
               $time, lat_count, frames_sent);
      errors++;
    end
    host_read_check(`LED_REG_FRAMES, led_panel_pkg::wb_data_t'(frames_sent), "frame count");
    if (ack_count != host_accesses) begin
      $display("ERROR at %0t: %0d acknowledges for %0d host accesses",
               $time, ack_count, host_accesses);
      errors++;
    end
    finish_test("host_port");

    // Partial frame cut short by a new sync
    start_test();
    frame = random_frame();
    drive_bits(frame, 30);
    frame = random_frame();
    send_frame(frame);
    wait_latch();
    finish_test("mid_frame_sync");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("ERROR at %0t: watchdog expired before the tests finished", $time);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
verilog/led_panel_pkg.sv
verilog/frame_loader.sv
verilog/chain_shifter.sv
verilog/status_collector.sv
verilog/led_driver_top.sv
test/led_driver_properties.sv
test/led_driver_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result decided from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module led_driver_tb \
  -o led_driver_sim > build.log 2>&1 && ./obj_dir/led_driver_sim > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
